// File: include/matrix_product_params.svh
// Width and size constants for the matrix product
`ifndef MATRIX_PRODUCT_PARAMS_SVH
`define MATRIX_PRODUCT_PARAMS_SVH

// Element width, signed
`define MATRIX_DATA_WIDTH 16

// Product and running sum width, signed
`define MATRIX_RESULT_WIDTH 32

// Largest dimension of either operand
`define MATRIX_MAX_SIZE 4

// Row or column index, 0 to MAX-1
`define MATRIX_INDEX_WIDTH 2

// Dimension value, 0 to MAX
`define MATRIX_SIZE_WIDTH 3

`endif

// File: design/matrix_product_pkg.sv
// Package with the element, result, index and size types and the controller states
`include "matrix_product_params.svh"

package matrix_product_pkg;

  // Operand element
  typedef logic signed [`MATRIX_DATA_WIDTH-1:0] data_t;

  // Product and accumulated sum
  typedef logic signed [`MATRIX_RESULT_WIDTH-1:0] result_t;

  // Row, column or inner index
  typedef logic [`MATRIX_INDEX_WIDTH-1:0] index_t;

  // Matrix dimension
  typedef logic [`MATRIX_SIZE_WIDTH-1:0] size_t;

  // Controller steps
  typedef enum logic [2:0] {
    STARTER,
    MATRIX_INPUT,
    OPERAND_READ,
    VECTOR_MULTIPLIER,
    SCALAR_ADDER,
    MATRIX_UPDATE
  } fsm_state_t;

endpackage

// File: design/matrix_product_fsm.sv
// Run controller: size check, load phase, multiply-add loop and result emission
`timescale 1ns/10ps
`include "matrix_product_params.svh"

module matrix_product_fsm (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start,
  input  matrix_product_pkg::size_t  size_a_i,
  input  matrix_product_pkg::size_t  size_a_j,
  input  matrix_product_pkg::size_t  size_b_i,
  input  matrix_product_pkg::size_t  size_b_j,
  input  matrix_product_pkg::index_t col,
  input  logic                       loaded,
  input  logic                       last_inner,
  input  logic                       last_element,
  input  logic                       multiply_ready,
  output logic                       buffer_clear,
  output logic                       load_enable,
  output logic                       counter_clear,
  output logic                       counter_step,
  output logic                       multiply_start,
  output logic                       acc_clear,
  output logic                       acc_add,
  output logic                       result_i_enable,
  output logic                       result_j_enable,
  output logic                       ready,
  output logic                       size_error
);

  localparam matrix_product_pkg::size_t MAX_SIZE = `MATRIX_MAX_SIZE;

  matrix_product_pkg::fsm_state_t state;
  logic                           sizes_ok;

  // One dimension in range 1..MAX
  function automatic logic dim_ok(input matrix_product_pkg::size_t dim);
    return (dim != '0) && (dim <= MAX_SIZE);
  endfunction

  //////////////////////////////////////////////////
  // Size check
  //////////////////////////////////////////////////

  // Inner dimensions must agree
  assign sizes_ok = (size_a_j == size_b_i) && dim_ok(size_a_i) && dim_ok(size_a_j) &&
                    dim_ok(size_b_i) && dim_ok(size_b_j);

  //////////////////////////////////////////////////
  // Decoded strobes
  //////////////////////////////////////////////////

  // Accepted start resets buffer pointers, counters and sum
  assign buffer_clear  = (state == matrix_product_pkg::STARTER) && start && sizes_ok;
  assign counter_clear = buffer_clear;
  assign load_enable   = (state == matrix_product_pkg::MATRIX_INPUT);
  assign acc_add       = (state == matrix_product_pkg::SCALAR_ADDER);

  // Emit cycle, sum already holds the last product
  assign result_j_enable = (state == matrix_product_pkg::MATRIX_UPDATE);
  assign result_i_enable = result_j_enable && (col == '0);
  assign acc_clear       = buffer_clear || result_j_enable;

  // Inner step after each add; col/row step only after emission
  assign counter_step = (acc_add && !last_inner) || result_j_enable;

  //////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state          <= matrix_product_pkg::STARTER;
      ready          <= 1'b0;
      size_error     <= 1'b0;
      multiply_start <= 1'b0;
    end else begin
      // Single-cycle pulses by default
      ready          <= 1'b0;
      multiply_start <= 1'b0;
      case (state)
        matrix_product_pkg::STARTER: begin
          if (start) begin
            size_error <= !sizes_ok;
            // Bad sizes end the run at once
            if (sizes_ok) begin
              state <= matrix_product_pkg::MATRIX_INPUT;
            end else begin
              ready <= 1'b1;
            end
          end
        end
        matrix_product_pkg::MATRIX_INPUT: begin
          if (loaded) begin
            state <= matrix_product_pkg::OPERAND_READ;
          end
        end
        matrix_product_pkg::OPERAND_READ: begin
          // Operands registered this cycle
          multiply_start <= 1'b1;
          state          <= matrix_product_pkg::VECTOR_MULTIPLIER;
        end
        matrix_product_pkg::VECTOR_MULTIPLIER: begin
          if (multiply_ready) begin
            state <= matrix_product_pkg::SCALAR_ADDER;
          end
        end
        matrix_product_pkg::SCALAR_ADDER: begin
          if (last_inner) begin
            state <= matrix_product_pkg::MATRIX_UPDATE;
          end else begin
            state <= matrix_product_pkg::OPERAND_READ;
          end
        end
        matrix_product_pkg::MATRIX_UPDATE: begin
          // Final element, ready the cycle after its strobe
          if (last_element) begin
            ready <= 1'b1;
            state <= matrix_product_pkg::STARTER;
          end else begin
            state <= matrix_product_pkg::OPERAND_READ;
          end
        end
        default: begin
          state <= matrix_product_pkg::STARTER;
        end
      endcase
    end
  end

endmodule

// File: design/matrix_index_counter.sv
// Nested row, column and inner index counter with last-step flags
`timescale 1ns/10ps

module matrix_index_counter (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       clear,
  input  logic                       step,
  input  matrix_product_pkg::size_t  size_a_i,
  input  matrix_product_pkg::size_t  size_a_j,
  input  matrix_product_pkg::size_t  size_b_j,
  output matrix_product_pkg::index_t row,
  output matrix_product_pkg::index_t col,
  output matrix_product_pkg::index_t inner,
  output logic                       last_inner,
  output logic                       last_element
);

  // Wrap limits, one below each size
  matrix_product_pkg::size_t row_limit;
  matrix_product_pkg::size_t col_limit;
  matrix_product_pkg::size_t inner_limit;
  logic                      last_col;
  logic                      last_row;

  assign row_limit   = size_a_i - 3'd1;
  assign col_limit   = size_b_j - 3'd1;
  assign inner_limit = size_a_j - 3'd1;

  // Flags from current indices
  assign last_inner   = ({1'b0, inner} == inner_limit);
  assign last_col     = ({1'b0, col} == col_limit);
  assign last_row     = ({1'b0, row} == row_limit);
  assign last_element = last_inner && last_col && last_row;

  // Inner fastest, then column, then row
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row   <= '0;
      col   <= '0;
      inner <= '0;
    end else if (clear) begin
      row   <= '0;
      col   <= '0;
      inner <= '0;
    end else if (step) begin
      if (last_inner) begin
        inner <= '0;
        if (last_col) begin
          col <= '0;
          // Wraps after the final row
          row <= last_row ? '0 : row + 2'd1;
        end else begin
          col <= col + 2'd1;
        end
      end else begin
        inner <= inner + 2'd1;
      end
    end
  end

endmodule

// File: design/matrix_operand_buffer.sv
// Operand storage for A and B with strobe-driven write pointers and registered reads
`timescale 1ns/10ps
`include "matrix_product_params.svh"

module matrix_operand_buffer (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       clear,
  input  logic                       load_enable,
  input  matrix_product_pkg::data_t  data_a,
  input  matrix_product_pkg::data_t  data_b,
  input  logic                       data_a_i_enable,
  input  logic                       data_a_j_enable,
  input  logic                       data_b_i_enable,
  input  logic                       data_b_j_enable,
  input  matrix_product_pkg::size_t  size_a_i,
  input  matrix_product_pkg::size_t  size_a_j,
  input  matrix_product_pkg::size_t  size_b_i,
  input  matrix_product_pkg::size_t  size_b_j,
  input  matrix_product_pkg::index_t row,
  input  matrix_product_pkg::index_t col,
  input  matrix_product_pkg::index_t inner,
  output matrix_product_pkg::data_t  operand_a,
  output matrix_product_pkg::data_t  operand_b,
  output logic                       loaded
);

  // Port 0 is A, port 1 is B
  matrix_product_pkg::data_t  wr_data [2];
  logic                       i_en    [2];
  logic                       j_en    [2];
  matrix_product_pkg::size_t  rows    [2];
  matrix_product_pkg::size_t  cols    [2];
  matrix_product_pkg::index_t rd_row  [2];
  matrix_product_pkg::index_t rd_col  [2];
  matrix_product_pkg::data_t  rd_data [2];
  logic                       done    [2];

  assign wr_data = '{data_a, data_b};
  assign i_en    = '{data_a_i_enable, data_b_i_enable};
  assign j_en    = '{data_a_j_enable, data_b_j_enable};
  assign rows    = '{size_a_i, size_b_i};
  assign cols    = '{size_a_j, size_b_j};

  // A read at (row, inner), B at (inner, col)
  assign rd_row = '{row, inner};
  assign rd_col = '{inner, col};

  assign operand_a = rd_data[0];
  assign operand_b = rd_data[1];
  assign loaded    = done[0] && done[1];

  for (genvar m = 0; m < 2; m++) begin : g_matrix
    matrix_product_pkg::data_t  mem [`MATRIX_MAX_SIZE][`MATRIX_MAX_SIZE];
    matrix_product_pkg::index_t wr_row;
    matrix_product_pkg::index_t wr_col;
    matrix_product_pkg::index_t row_eff;
    matrix_product_pkg::index_t col_eff;
    logic                       started;
    logic                       last_pos;

    // I enable opens a row, the first one opens row 0
    assign row_eff  = i_en[m] ? (started ? wr_row + 2'd1 : '0) : wr_row;
    assign col_eff  = i_en[m] ? '0 : wr_col;
    assign last_pos = ({1'b0, row_eff} == rows[m] - 3'd1) &&
                      ({1'b0, col_eff} == cols[m] - 3'd1);

    // Write pointers
    always_ff @(posedge CLK or posedge RST) begin
      if (RST) begin
        wr_row  <= '0;
        wr_col  <= '0;
        started <= 1'b0;
        done[m] <= 1'b0;
      end else if (clear) begin
        wr_row  <= '0;
        wr_col  <= '0;
        started <= 1'b0;
        done[m] <= 1'b0;
      end else if (load_enable && j_en[m]) begin
        wr_row  <= row_eff;
        wr_col  <= col_eff + 2'd1;
        started <= 1'b1;
        if (last_pos) begin
          done[m] <= 1'b1;
        end
      end
    end

    // Element storage and registered read
    always_ff @(posedge CLK) begin
      if (load_enable && j_en[m]) begin
        mem[row_eff][col_eff] <= wr_data[m];
      end
      rd_data[m] <= mem[rd_row[m]][rd_col[m]];
    end
  end

endmodule

// File: design/scalar_multiplier.sv
// Signed radix-2 shift-add multiplier with start and ready
`timescale 1ns/10ps
`include "matrix_product_params.svh"

module scalar_multiplier (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  matrix_product_pkg::data_t   multiplicand,
  input  matrix_product_pkg::data_t   multiplier,
  output logic                        ready,
  output matrix_product_pkg::result_t product
);

  localparam int DW = `MATRIX_DATA_WIDTH;
  localparam int RW = `MATRIX_RESULT_WIDTH;
  localparam int CW = $clog2(DW) + 1;

  logic [DW-1:0] mag_a;
  logic [DW-1:0] mag_b;
  logic [RW-1:0] mcand_q;
  logic [DW-1:0] mplier_q;
  logic [RW-1:0] acc_q;
  logic          neg_q;
  logic          busy;
  logic [CW-1:0] count;

  // Operand magnitudes, -2^15 maps to 2^15
  assign mag_a = multiplicand[DW-1] ? DW'(-multiplicand) : multiplicand;
  assign mag_b = multiplier[DW-1] ? DW'(-multiplier) : multiplier;

  // Sign applied after the last partial product
  assign product = neg_q ? -acc_q : acc_q;

  // Bit 0 taken at start, one more bit per cycle
  always_ff @(posedge CLK) begin
    if (start) begin
      acc_q    <= mag_b[0] ? RW'(mag_a) : '0;
      mcand_q  <= RW'(mag_a) << 1;
      mplier_q <= mag_b >> 1;
      neg_q    <= multiplicand[DW-1] ^ multiplier[DW-1];
    end else if (busy) begin
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // Iteration count and ready pulse
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      count <= '0;
      ready <= 1'b0;
    end else begin
      ready <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        count <= CW'(1);
      end else if (busy) begin
        count <= count + CW'(1);
        // Last bit folded in this cycle
        if (count == CW'(DW - 1)) begin
          busy  <= 1'b0;
          ready <= 1'b1;
        end
      end
    end
  end

endmodule

// File: design/scalar_accumulator.sv
// Clearable saturating accumulator of signed products
`timescale 1ns/10ps
`include "matrix_product_params.svh"

module scalar_accumulator (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        clear,
  input  logic                        add,
  input  matrix_product_pkg::result_t addend,
  output matrix_product_pkg::result_t sum
);

  localparam int RW = `MATRIX_RESULT_WIDTH;

  // Saturation limits
  localparam matrix_product_pkg::result_t MAX_SUM = {1'b0, {(RW - 1){1'b1}}};
  localparam matrix_product_pkg::result_t MIN_SUM = {1'b1, {(RW - 1){1'b0}}};

  matrix_product_pkg::result_t raw_sum;
  logic                        overflow;

  // Overflow when like signs give a result of the other sign
  assign raw_sum  = sum + addend;
  assign overflow = (sum[RW-1] == addend[RW-1]) && (raw_sum[RW-1] != sum[RW-1]);

  // Clear wins over add
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum <= '0;
    end else if (clear) begin
      sum <= '0;
    end else if (add) begin
      sum <= overflow ? (addend[RW-1] ? MIN_SUM : MAX_SUM) : raw_sum;
    end
  end

endmodule

// File: design/matrix_product.sv
// Matrix product top: controller, index counter, operand buffer, multiplier, accumulator
`timescale 1ns/10ps

module matrix_product (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  matrix_product_pkg::size_t   size_a_i,
  input  matrix_product_pkg::size_t   size_a_j,
  input  matrix_product_pkg::size_t   size_b_i,
  input  matrix_product_pkg::size_t   size_b_j,
  input  matrix_product_pkg::data_t   data_a,
  input  logic                        data_a_i_enable,
  input  logic                        data_a_j_enable,
  input  matrix_product_pkg::data_t   data_b,
  input  logic                        data_b_i_enable,
  input  logic                        data_b_j_enable,
  output logic                        ready,
  output logic                        size_error,
  output matrix_product_pkg::result_t result,
  output logic                        result_i_enable,
  output logic                        result_j_enable
);

  //////////////////////////////////////////////////
  // Internal signals
  //////////////////////////////////////////////////

  // Controller strobes
  logic buffer_clear;
  logic load_enable;
  logic counter_clear;
  logic counter_step;
  logic multiply_start;
  logic acc_clear;
  logic acc_add;

  // Loop indices and flags
  matrix_product_pkg::index_t row;
  matrix_product_pkg::index_t col;
  matrix_product_pkg::index_t inner;
  logic                       last_inner;
  logic                       last_element;
  logic                       loaded;

  // Arithmetic path
  matrix_product_pkg::data_t   operand_a;
  matrix_product_pkg::data_t   operand_b;
  matrix_product_pkg::result_t product;
  logic                        multiply_ready;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  matrix_product_fsm fsm_i (
    .CLK(CLK), .RST(RST), .start(start),
    .size_a_i(size_a_i), .size_a_j(size_a_j), .size_b_i(size_b_i), .size_b_j(size_b_j),
    .col(col), .loaded(loaded), .last_inner(last_inner), .last_element(last_element),
    .multiply_ready(multiply_ready), .buffer_clear(buffer_clear),
    .load_enable(load_enable), .counter_clear(counter_clear), .counter_step(counter_step),
    .multiply_start(multiply_start), .acc_clear(acc_clear), .acc_add(acc_add),
    .result_i_enable(result_i_enable), .result_j_enable(result_j_enable),
    .ready(ready), .size_error(size_error)
  );

  matrix_index_counter counter_i (
    .CLK(CLK), .RST(RST), .clear(counter_clear), .step(counter_step),
    .size_a_i(size_a_i), .size_a_j(size_a_j), .size_b_j(size_b_j),
    .row(row), .col(col), .inner(inner),
    .last_inner(last_inner), .last_element(last_element)
  );

  matrix_operand_buffer buffer_i (
    .CLK(CLK), .RST(RST), .clear(buffer_clear), .load_enable(load_enable),
    .data_a(data_a), .data_b(data_b),
    .data_a_i_enable(data_a_i_enable), .data_a_j_enable(data_a_j_enable),
    .data_b_i_enable(data_b_i_enable), .data_b_j_enable(data_b_j_enable),
    .size_a_i(size_a_i), .size_a_j(size_a_j), .size_b_i(size_b_i), .size_b_j(size_b_j),
    .row(row), .col(col), .inner(inner),
    .operand_a(operand_a), .operand_b(operand_b), .loaded(loaded)
  );

  scalar_multiplier multiplier_i (
    .CLK(CLK), .RST(RST), .start(multiply_start),
    .multiplicand(operand_a), .multiplier(operand_b),
    .ready(multiply_ready), .product(product)
  );

  // Sum is the result, strobed before it clears
  scalar_accumulator accumulator_i (
    .CLK(CLK), .RST(RST), .clear(acc_clear), .add(acc_add),
    .addend(product), .sum(result)
  );

endmodule

// File: verification/matrix_product_tb.sv
// Testbench for the matrix product: clock, reset, stimulus, reference model and checks
`timescale 1ns/10ps
`include "matrix_product_params.svh"

module matrix_product_tb;

  localparam int MAX = `MATRIX_MAX_SIZE;
  localparam int READY_TIMEOUT = 6000;
  // Saturation limits of the running sum
  localparam longint SUM_MAX = (longint'(1) <<< (`MATRIX_RESULT_WIDTH - 1)) - 1;
  localparam longint SUM_MIN = -(longint'(1) <<< (`MATRIX_RESULT_WIDTH - 1));

  logic                        CLK = 1'b0;
  logic                        RST;
  logic                        start;
  matrix_product_pkg::size_t   size_a_i;
  matrix_product_pkg::size_t   size_a_j;
  matrix_product_pkg::size_t   size_b_i;
  matrix_product_pkg::size_t   size_b_j;
  matrix_product_pkg::data_t   data_a;
  logic                        data_a_i_enable;
  logic                        data_a_j_enable;
  matrix_product_pkg::data_t   data_b;
  logic                        data_b_i_enable;
  logic                        data_b_j_enable;
  logic                        ready;
  logic                        size_error;
  matrix_product_pkg::result_t result;
  logic                        result_i_enable;
  logic                        result_j_enable;

  // Operands of the current run and expected C, row-major
  matrix_product_pkg::data_t   a_mat [MAX][MAX];
  matrix_product_pkg::data_t   b_mat [MAX][MAX];
  matrix_product_pkg::result_t expected_q [$];
  logic                        expected_col0_q [$];

  logic [31:0] rng_state = 32'd56;
  int          mismatch_count = 0;
  int          failure_count = 0;
  logic        timed_out = 1'b0;

  // 4 ns clock
  always #2 CLK = ~CLK;

  matrix_product matrix_product_i (
    .CLK(CLK), .RST(RST), .start(start),
    .size_a_i(size_a_i), .size_a_j(size_a_j), .size_b_i(size_b_i), .size_b_j(size_b_j),
    .data_a(data_a), .data_a_i_enable(data_a_i_enable), .data_a_j_enable(data_a_j_enable),
    .data_b(data_b), .data_b_i_enable(data_b_i_enable), .data_b_j_enable(data_b_j_enable),
    .ready(ready), .size_error(size_error), .result(result),
    .result_i_enable(result_i_enable), .result_j_enable(result_j_enable)
  );

  //////////////////////////////////////////////////
  // Random values and reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Clamp to the signed 32-bit range
  function automatic matrix_product_pkg::result_t saturate(input longint value);
    if (value > SUM_MAX) begin
      return matrix_product_pkg::result_t'(SUM_MAX);
    end else if (value < SUM_MIN) begin
      return matrix_product_pkg::result_t'(SUM_MIN);
    end
    return matrix_product_pkg::result_t'(value);
  endfunction

  // Sum clamped after every product, k in ascending order
  task automatic push_expected(input int ra, input int ca, input int cb);
    longint acc;
    for (int i = 0; i < ra; i++) begin
      for (int j = 0; j < cb; j++) begin
        acc = 0;
        for (int k = 0; k < ca; k++) begin
          acc = longint'(saturate(acc + longint'(a_mat[i][k]) * longint'(b_mat[k][j])));
        end
        expected_q.push_back(saturate(acc));
        expected_col0_q.push_back(j == 0);
      end
    end
  endtask

  task automatic fill_random(input int ra, input int ca, input int cb);
    for (int i = 0; i < ra; i++) begin
      for (int k = 0; k < ca; k++) begin
        rng_state = xorshift32(rng_state);
        a_mat[i][k] = matrix_product_pkg::data_t'(rng_state[15:0]);
      end
    end
    for (int k = 0; k < ca; k++) begin
      for (int j = 0; j < cb; j++) begin
        rng_state = xorshift32(rng_state);
        b_mat[k][j] = matrix_product_pkg::data_t'(rng_state[15:0]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // A and B interleave at random, idle cycles included
  task automatic stream_operands(input int ra, input int ca, input int cb);
    int   a_count;
    int   b_count;
    logic send_a;
    logic send_b;
    a_count = 0;
    b_count = 0;
    while (a_count < ra * ca || b_count < ca * cb) begin
      rng_state = xorshift32(rng_state);
      send_a = (a_count < ra * ca) && (rng_state[0] || b_count >= ca * cb);
      send_b = (b_count < ca * cb) && (rng_state[1] || a_count >= ra * ca);
      data_a_j_enable = send_a;
      data_a_i_enable = send_a && (a_count % ca == 0);
      data_a          = send_a ? a_mat[a_count / ca][a_count % ca] : '0;
      data_b_j_enable = send_b;
      data_b_i_enable = send_b && (b_count % cb == 0);
      data_b          = send_b ? b_mat[b_count / cb][b_count % cb] : '0;
      if (send_a) a_count++;
      if (send_b) b_count++;
      @(posedge CLK);
      #1;
    end
    data_a_i_enable = 1'b0;
    data_a_j_enable = 1'b0;
    data_b_i_enable = 1'b0;
    data_b_j_enable = 1'b0;
  endtask

  task automatic pulse_start(input int sai, input int saj, input int sbi, input int sbj);
    size_a_i = matrix_product_pkg::size_t'(sai);
    size_a_j = matrix_product_pkg::size_t'(saj);
    size_b_i = matrix_product_pkg::size_t'(sbi);
    size_b_j = matrix_product_pkg::size_t'(sbj);
    start    = 1'b1;
    @(posedge CLK);
    #1;
    start = 1'b0;
  endtask

  // Ready must come after every expected element, and only for one cycle
  task automatic wait_for_ready(input logic expect_error);
    int cycles;
    cycles = 0;
    do begin
      @(negedge CLK);
      cycles++;
    end while (ready !== 1'b1 && cycles < READY_TIMEOUT);
    if (ready !== 1'b1) begin
      failure_count++;
      timed_out = 1'b1;
      $display("timeout: no ready within %0d cycles", READY_TIMEOUT);
    end else begin
      assert (size_error === expect_error) else begin
        mismatch_count++;
        $display("mismatch size_error: got %h expected %h", size_error, expect_error);
      end
      assert (expected_q.size() == 0) else begin
        failure_count++;
        $display("ready came with %0d result elements still missing", expected_q.size());
      end
      @(negedge CLK);
      assert (ready === 1'b0) else begin
        failure_count++;
        $display("ready stayed high for more than one cycle");
      end
    end
    @(posedge CLK);
    #1;
  endtask

  task automatic run_product(input int ra, input int ca, input int cb);
    if (!timed_out) begin
      push_expected(ra, ca, cb);
      pulse_start(ra, ca, ca, cb);
      stream_operands(ra, ca, cb);
      wait_for_ready(1'b0);
    end
  endtask

  // Bad sizes, no element expected
  task automatic reject_run(input int sai, input int saj, input int sbi, input int sbj);
    if (!timed_out) begin
      pulse_start(sai, saj, sbi, sbj);
      wait_for_ready(1'b1);
    end
  endtask

  //////////////////////////////////////////////////
  // Result monitor
  //////////////////////////////////////////////////

  // Outputs sampled mid-cycle
  always @(negedge CLK) begin
    if (RST === 1'b0) begin
      if (result_j_enable === 1'b1) begin
        assert (expected_q.size() > 0) else begin
          failure_count++;
          $display("result strobe while no element was expected");
        end
        if (expected_q.size() > 0) begin
          assert (result === expected_q[0]) else begin
            mismatch_count++;
            $display("mismatch result: got %h expected %h", result, expected_q[0]);
          end
          assert (result_i_enable === expected_col0_q[0]) else begin
            mismatch_count++;
            $display("mismatch result_i_enable: got %h expected %h",
                     result_i_enable, expected_col0_q[0]);
          end
          void'(expected_q.pop_front());
          void'(expected_col0_q.pop_front());
        end
      end else begin
        assert (result_i_enable !== 1'b1) else begin
          failure_count++;
          $display("result_i_enable high without result_j_enable");
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    RST             = 1'b1;
    start           = 1'b0;
    size_a_i        = '0;
    size_a_j        = '0;
    size_b_i        = '0;
    size_b_j        = '0;
    data_a          = '0;
    data_a_i_enable = 1'b0;
    data_a_j_enable = 1'b0;
    data_b          = '0;
    data_b_i_enable = 1'b0;
    data_b_j_enable = 1'b0;
    repeat (5) @(posedge CLK);
    #1;
    RST = 1'b0;

    // Quiet outputs with no start
    repeat (8) begin
      @(negedge CLK);
      assert (ready === 1'b0 && size_error === 1'b0 &&
              result_i_enable === 1'b0 && result_j_enable === 1'b0) else begin
        failure_count++;
        $display("outputs active after reset before any start");
      end
    end
    @(posedge CLK);
    #1;

    // Small 2x2 by 2x2
    a_mat[0][0] = 16'sd1;
    a_mat[0][1] = 16'sd2;
    a_mat[1][0] = 16'sd3;
    a_mat[1][1] = -16'sd4;
    b_mat[0][0] = 16'sd5;
    b_mat[0][1] = -16'sd6;
    b_mat[1][0] = 16'sd7;
    b_mat[1][1] = 16'sd8;
    run_product(2, 2, 2);

    // Random runs back-to-back
    fill_random(2, 3, 4);
    run_product(2, 3, 4);
    fill_random(1, 1, 1);
    run_product(1, 1, 1);
    fill_random(4, 4, 4);
    run_product(4, 4, 4);

    // Full-scale operands, both saturation directions
    for (int k = 0; k < 4; k++) begin
      a_mat[0][k] = 16'sh7FFF;
      a_mat[1][k] = 16'sh8000;
      b_mat[k][0] = 16'sh7FFF;
      b_mat[k][1] = 16'sh8000;
    end
    run_product(2, 4, 2);

    // Inner mismatch, zero dimension, dimension of 5
    reject_run(2, 3, 2, 2);
    reject_run(0, 2, 2, 2);
    reject_run(2, 2, 2, 5);

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
design/matrix_product_pkg.sv
design/matrix_product_fsm.sv
design/matrix_index_counter.sv
design/matrix_operand_buffer.sv
design/scalar_multiplier.sv
design/scalar_accumulator.sv
design/matrix_product.sv
verification/matrix_product_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= matrix_product_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
